// ==== source/sorted_list_pkg.sv ====
`default_nettype none

package sorted_list_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int KEY_WIDTH    = 8;
    localparam int LIST_DEPTH   = 32;
    localparam int INDEX_WIDTH  = $clog2(LIST_DEPTH);
    localparam int LENGTH_WIDTH = $clog2(LIST_DEPTH + 1);

    typedef logic [KEY_WIDTH - 1:0]    key_t;
    typedef logic [INDEX_WIDTH - 1:0]  index_t;
    typedef logic [LENGTH_WIDTH - 1:0] length_t;

    // ----------------------------------------
    // command and response
    // ----------------------------------------
    typedef enum logic [1:0] {
        OP_FIND,
        OP_INSERT,
        OP_DELETE
    } list_op_e;

    typedef struct packed {
        list_op_e op;
        key_t     key;
    } list_cmd_t;

    // rank is a lower bound, so it may equal the length.
    typedef struct packed {
        list_op_e op;
        logic     hit;
        logic     changed;
        length_t  rank;
        length_t  length;
    } list_rsp_t;

endpackage

`default_nettype wire

// ==== source/ordered_vector.sv ====
`timescale 1ns/1ps
`default_nettype none

module ordered_vector
    import sorted_list_pkg::*;
(
    input  wire     clk,
    input  wire     reset,

    input  wire index_t index,

    // one operation at a time.
    input  wire     get,
    input  wire     insert,
    input  wire     remove,

    input  wire key_t data_in,
    output key_t    data_out,

    output length_t length,
    output logic    ready
);

    typedef enum logic [2:0] {
        ST_READY,
        ST_INS_READ,
        ST_INS_WRITE,
        ST_INS_DONE,
        ST_REM_READ,
        ST_REM_WRITE,
        ST_REM_DONE
    } state_e;

    key_t    mem [LIST_DEPTH];
    state_e  state;

    // shift cursor and the word in flight.
    length_t j;
    length_t j_below;
    length_t j_above;
    length_t last_pos;
    key_t    tmp;

    assign ready    = (state == ST_READY);
    assign j_below  = j - length_t'(1);
    assign j_above  = j + length_t'(1);
    assign last_pos = length - length_t'(1);

    // ----------------------------------------
    // state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_READY;
        end else begin
            case (state)
                ST_READY: begin
                    if (insert) begin
                        // appending at the tail needs no shift.
                        state <= (length_t'(index) != length) ? ST_INS_READ : ST_INS_DONE;
                    end else if (remove) begin
                        state <= (length_t'(index) != last_pos) ? ST_REM_READ : ST_REM_DONE;
                    end
                end
                ST_INS_READ: state <= ST_INS_WRITE;
                ST_INS_WRITE: begin
                    state <= (j_below == length_t'(index)) ? ST_INS_DONE : ST_INS_READ;
                end
                ST_INS_DONE: state <= ST_READY;
                ST_REM_READ: state <= ST_REM_WRITE;
                ST_REM_WRITE: begin
                    state <= (j_above == last_pos) ? ST_REM_DONE : ST_REM_READ;
                end
                ST_REM_DONE: state <= ST_READY;
                default: state <= ST_READY;
            endcase
        end
    end

    // cursor walks down on insert, up on remove.
    always_ff @(posedge clk) begin
        if (reset) begin
            j <= '0;
        end else begin
            case (state)
                ST_READY: begin
                    if (insert) begin
                        j <= length;
                    end else if (remove) begin
                        j <= length_t'(index);
                    end
                end
                ST_INS_WRITE: j <= j_below;
                ST_REM_WRITE: j <= j_above;
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        case (state)
            ST_INS_READ: tmp <= mem[index_t'(j_below)];
            ST_REM_READ: tmp <= mem[index_t'(j_above)];
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        case (state)
            ST_INS_WRITE,
            ST_REM_WRITE: mem[index_t'(j)] <= tmp;
            ST_INS_DONE:  mem[index] <= data_in;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            length <= '0;
        end else begin
            case (state)
                ST_INS_DONE: length <= length + length_t'(1);
                ST_REM_DONE: length <= length - length_t'(1);
                default: ;
            endcase
        end
    end

    // read port with one cycle latency.
    always_ff @(posedge clk) begin
        if (ready && get) begin
            data_out <= mem[index];
        end
    end

endmodule

`default_nettype wire

// ==== source/rank_search.sv ====
`timescale 1ns/1ps
`default_nettype none

module rank_search
    import sorted_list_pkg::*;
(
    input  wire     clk,
    input  wire     reset,

    input  wire     start,
    input  wire key_t key,
    input  wire length_t length,

    // vector read port.
    output index_t  rd_index,
    output logic    get,
    input  wire key_t rd_data,

    output logic    done,
    output length_t rank,
    output logic    found
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PROBE,
        S_COMPARE,
        S_CHECK
    } state_e;

    state_e  state;

    // search window is [lo, hi).
    length_t lo;
    length_t hi;
    length_t mid;
    key_t    key_q;
    logic    narrowed;
    logic    in_range;

    assign narrowed = (lo == hi);
    assign in_range = (lo < length);
    assign mid      = lo + ((hi - lo) >> 1);

    // the final probe reads the element at the rank itself.
    assign get      = (state == S_PROBE) && (!narrowed || in_range);
    assign rd_index = index_t'(mid);

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_PROBE;
                    end
                end
                S_PROBE: begin
                    if (!narrowed) begin
                        state <= S_COMPARE;
                    end else if (in_range) begin
                        state <= S_CHECK;
                    end else begin
                        // past the last key there is nothing to read.
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end
                end
                S_COMPARE: state <= S_PROBE;
                S_CHECK: begin
                    state <= S_IDLE;
                    done  <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // bounds and result
    // ----------------------------------------
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (start) begin
                    lo    <= '0;
                    hi    <= length;
                    key_q <= key;
                end
            end
            S_PROBE: begin
                if (narrowed && !in_range) begin
                    rank  <= lo;
                    found <= 1'b0;
                end
            end
            S_COMPARE: begin
                if (rd_data < key_q) begin
                    lo <= mid + length_t'(1);
                end else begin
                    hi <= mid;
                end
            end
            S_CHECK: begin
                rank  <= lo;
                found <= (rd_data == key_q);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/list_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module list_controller
    import sorted_list_pkg::*;
(
    input  wire     clk,
    input  wire     reset,

    input  wire     cmd_valid,
    input  wire list_cmd_t cmd,
    output logic    busy,
    output logic    rsp_valid,
    output list_rsp_t rsp,

    // search side.
    output logic    search_start,
    output key_t    search_key,
    input  wire     search_done,
    input  wire length_t search_rank,
    input  wire     search_found,

    // vector side.
    input  wire     vec_ready,
    input  wire length_t length,
    output logic    vec_insert,
    output logic    vec_remove,
    output index_t  mod_index,
    output logic    mod_active,
    output key_t    vec_data
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_SEARCH,
        C_STROBE,
        C_WAIT
    } state_e;

    state_e    state;
    list_cmd_t cmd_q;

    logic accept;
    logic do_insert;
    logic do_remove;
    logic finish_plain;
    logic finish_mod;

    assign accept = cmd_valid && (state == C_IDLE);
    assign busy   = (state != C_IDLE);

    // decision once the rank is known.
    assign do_insert = (cmd_q.op == OP_INSERT) && !search_found &&
                       (length < length_t'(LIST_DEPTH));
    assign do_remove = (cmd_q.op == OP_DELETE) && search_found;

    assign finish_plain = (state == C_SEARCH) && search_done && !(do_insert || do_remove);
    assign finish_mod   = (state == C_WAIT) && vec_ready;

    assign search_key = cmd_q.key;
    assign vec_data   = cmd_q.key;
    assign mod_index  = index_t'(search_rank);
    assign mod_active = (state == C_STROBE) || (state == C_WAIT);

    // index must stay on the rank until ready returns.
    assign vec_insert = (state == C_STROBE) && vec_ready && (cmd_q.op == OP_INSERT);
    assign vec_remove = (state == C_STROBE) && vec_ready && (cmd_q.op == OP_DELETE);

    // ----------------------------------------
    // sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= C_IDLE;
            search_start <= 1'b0;
            rsp_valid    <= 1'b0;
        end else begin
            search_start <= 1'b0;
            rsp_valid    <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (accept) begin
                        state        <= C_SEARCH;
                        search_start <= 1'b1;
                    end
                end
                C_SEARCH: begin
                    if (finish_plain) begin
                        state     <= C_IDLE;
                        rsp_valid <= 1'b1;
                    end else if (search_done) begin
                        state <= C_STROBE;
                    end
                end
                C_STROBE: begin
                    if (vec_ready) begin
                        state <= C_WAIT;
                    end
                end
                C_WAIT: begin
                    if (finish_mod) begin
                        state     <= C_IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // command and response
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
        if (finish_plain || finish_mod) begin
            rsp.op      <= cmd_q.op;
            rsp.hit     <= search_found;
            rsp.changed <= finish_mod;
            rsp.rank    <= search_rank;
            // vector length is already updated once ready is back.
            rsp.length  <= length;
        end
    end

endmodule

`default_nettype wire

// ==== source/sorted_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module sorted_list
    import sorted_list_pkg::*;
(
    input  wire     clk,
    input  wire     reset,

    input  wire     cmd_valid,
    input  wire list_cmd_t cmd,
    output logic    busy,

    output logic    rsp_valid,
    output list_rsp_t rsp,
    output length_t length
);

    logic    search_start;
    key_t    search_key;
    logic    search_done;
    length_t search_rank;
    logic    search_found;
    logic    search_get;
    index_t  rd_index;

    logic    vec_insert;
    logic    vec_remove;
    logic    vec_ready;
    logic    vec_get;
    index_t  vec_index;
    key_t    vec_data;
    key_t    vec_out;
    index_t  mod_index;
    logic    mod_active;

    // search owns the vector index except during a modify.
    assign vec_index = mod_active ? mod_index : rd_index;
    assign vec_get   = mod_active ? 1'b0 : search_get;

    list_controller u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .busy         (busy),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .search_start (search_start),
        .search_key   (search_key),
        .search_done  (search_done),
        .search_rank  (search_rank),
        .search_found (search_found),
        .vec_ready    (vec_ready),
        .length       (length),
        .vec_insert   (vec_insert),
        .vec_remove   (vec_remove),
        .mod_index    (mod_index),
        .mod_active   (mod_active),
        .vec_data     (vec_data)
    );

    rank_search u_search (
        .clk      (clk),
        .reset    (reset),
        .start    (search_start),
        .key      (search_key),
        .length   (length),
        .rd_index (rd_index),
        .get      (search_get),
        .rd_data  (vec_out),
        .done     (search_done),
        .rank     (search_rank),
        .found    (search_found)
    );

    ordered_vector u_vector (
        .clk      (clk),
        .reset    (reset),
        .index    (vec_index),
        .get      (vec_get),
        .insert   (vec_insert),
        .remove   (vec_remove),
        .data_in  (vec_data),
        .data_out (vec_out),
        .length   (length),
        .ready    (vec_ready)
    );

endmodule

`default_nettype wire

// ==== test/sorted_list_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sorted_list_checker
    import sorted_list_pkg::*;
(
    input  wire     clk,
    input  wire     reset,

    // DUT side.
    input  wire     rsp_valid,
    input  wire list_rsp_t rsp,
    input  wire     busy,
    input  wire length_t length,

    // expected responses, in command order.
    input  wire     exp_valid,
    input  wire list_rsp_t exp_rsp,

    input  wire     report,
    input  int      other_errors,
    output int      pending,
    output int      error_total
);

    list_rsp_t expected[$];

    int mismatches = 0;
    int extras     = 0;
    int missing    = 0;
    int responses  = 0;

    function automatic string format_rsp(input list_rsp_t r);
        return $sformatf("rank %0d hit %0b chg %0b len %0d", r.rank, r.hit, r.changed,
                         r.length);
    endfunction

    // ----------------------------------------
    // compare each response pulse
    // ----------------------------------------
    always @(posedge clk) begin
        list_rsp_t want;
        if (!reset) begin
            if (exp_valid) begin
                expected.push_back(exp_rsp);
            end
            if (rsp_valid) begin
                responses++;
                if (expected.size() == 0) begin
                    extras++;
                    $display("unexpected response at %0t with no command outstanding", $time);
                end else begin
                    want = expected.pop_front();
                    if (rsp !== want) begin
                        mismatches++;
                        $display("[FAIL] %0t: op %0d got %s, want %s", $time, want.op,
                                 format_rsp(rsp), format_rsp(want));
                    end
                    if (length !== want.length) begin
                        mismatches++;
                        $display("[FAIL] %0t: length port %0d, want %0d", $time, length,
                                 want.length);
                    end
                end
                // busy falls together with the pulse.
                if (busy) begin
                    mismatches++;
                    $display("[FAIL] %0t: busy still high with the response", $time);
                end
            end
        end
        pending <= expected.size();
    end

    // ----------------------------------------
    // closing summary
    // ----------------------------------------
    always @(posedge report) begin
        missing = expected.size();
        if (missing != 0) begin
            $display("%0d expected responses never arrived", missing);
        end
        error_total = mismatches + extras + missing + other_errors;
        $display("errors: %0d mismatched, %0d missing, %0d extra, %0d other (%0d responses)",
                 mismatches, missing, extras, other_errors, responses);
    end

endmodule

`default_nettype wire

// ==== test/sorted_list_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sorted_list_tb
    import sorted_list_pkg::*;
();

    localparam int WAIT_LIMIT = 400;

    logic      clk;
    logic      reset;
    logic      cmd_valid;
    list_cmd_t cmd;
    logic      busy;
    logic      rsp_valid;
    list_rsp_t rsp;
    length_t   length;

    logic      exp_valid;
    list_rsp_t exp_rsp;
    logic      report;
    int        other_errors;
    int        pending;
    int        error_total;

    logic [31:0] lcg_state;
    logic [31:0] pick;
    key_t        model[$];

    sorted_list dut0 (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .length    (length)
    );

    sorted_list_checker chk0 (
        .clk          (clk),
        .reset        (reset),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .busy         (busy),
        .length       (length),
        .exp_valid    (exp_valid),
        .exp_rsp      (exp_rsp),
        .report       (report),
        .other_errors (other_errors),
        .pending      (pending),
        .error_total  (error_total)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // stimulus helpers and reference model
    // ----------------------------------------
    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // small key range so that duplicates show up.
    function automatic key_t random_key();
        logic [31:0] bits;
        bits = lcg_step();
        return bits[23:16] & 8'h3f;
    endfunction

    function automatic logic in_model(input key_t k);
        foreach (model[i]) begin
            if (model[i] == k) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic key_t fresh_key();
        key_t k;
        k = random_key();
        for (int n = 0; n < 256 && in_model(k); n++) begin
            k = random_key();
        end
        return k;
    endfunction

    // expected response for one command; also updates the sorted model.
    function automatic list_rsp_t model_apply(input list_cmd_t c);
        list_rsp_t r;
        int        pos;
        pos = 0;
        while (pos < model.size() && model[pos] < c.key) begin
            pos++;
        end
        r.op      = c.op;
        r.hit     = (pos < model.size()) && (model[pos] == c.key);
        r.changed = 1'b0;
        r.rank    = length_t'(pos);
        if (c.op == OP_INSERT && !r.hit && model.size() < LIST_DEPTH) begin
            model.insert(pos, c.key);
            r.changed = 1'b1;
        end else if (c.op == OP_DELETE && r.hit) begin
            model.delete(pos);
            r.changed = 1'b1;
        end
        r.length = length_t'(model.size());
        return r;
    endfunction

    task automatic abort_run(input string what);
        $display("%s at %0t", what, $time);
        other_errors++;
        report = 1'b1;
        #1;
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic send(input list_op_e op, input key_t key);
        list_cmd_t c;
        int        waited;
        waited = 0;
        @(negedge clk);
        while (busy && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (busy) begin
            abort_run("timed out waiting for busy to fall");
        end else begin
            c.op  = op;
            c.key = key;
            @(posedge clk);
            cmd_valid <= 1'b1;
            cmd       <= c;
            exp_valid <= 1'b1;
            exp_rsp   <= model_apply(c);
            @(posedge clk);
            cmd_valid <= 1'b0;
            exp_valid <= 1'b0;
        end
    endtask

    task automatic find_all();
        foreach (model[i]) begin
            send(OP_FIND, model[i]);
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        list_cmd_t dropped;
        int        waited;
        lcg_state    = 32'h141;
        reset        = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        exp_valid    = 1'b0;
        exp_rsp      = '0;
        report       = 1'b0;
        other_errors = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (busy || rsp_valid || length != '0) begin
            other_errors++;
            $display("[FAIL] %0t: busy, rsp_valid or length not idle after reset", $time);
        end

        send(OP_FIND, 8'h10);
        repeat (12) begin
            send(OP_INSERT, fresh_key());
            find_all();
        end

        // duplicates, then deletes at head, tail, middle and an absent key.
        send(OP_INSERT, model[3]);
        send(OP_INSERT, model[0]);
        send(OP_DELETE, model[0]);
        send(OP_DELETE, model[model.size() - 1]);
        send(OP_DELETE, model[4]);
        send(OP_DELETE, fresh_key());
        find_all();

        // full list rejects a new key.
        while (model.size() < LIST_DEPTH) begin
            send(OP_INSERT, fresh_key());
        end
        send(OP_INSERT, fresh_key());
        send(OP_DELETE, model[10]);
        send(OP_INSERT, fresh_key());
        find_all();

        // a command during a long delete gets no response.
        send(OP_DELETE, model[0]);
        @(negedge clk);
        if (!busy) begin
            other_errors++;
            $display("[FAIL] %0t: busy low right after an accepted command", $time);
        end
        dropped.op  = OP_DELETE;
        dropped.key = model[5];
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= dropped;
        @(posedge clk);
        cmd_valid <= 1'b0;

        repeat (80) begin
            pick = lcg_step();
            case (pick[25:24])
                2'd0:    send(OP_FIND, random_key());
                2'd1:    send(OP_INSERT, random_key());
                default: send(OP_DELETE, random_key());
            endcase
        end

        waited = 0;
        @(negedge clk);
        while (pending != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        report = 1'b1;
        #1;
        if (error_total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/sorted_list_pkg.sv
source/ordered_vector.sv
source/rank_search.sv
source/list_controller.sv
source/sorted_list.sv
test/sorted_list_checker.sv
test/sorted_list_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sorted list testbench with Verilator.

cd "$(dirname "$0")" || exit 1

top=sorted_list_tb
log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not installed or not on PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module "$top" -o "$top"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation PASSED" "$log"; then
    exit 0
fi
exit 1
